// File: design/prefix_adder_pkg.sv
package prefix_adder_pkg;

    // default operand width
    localparam int DATA_W = 32;

    // encode, three prefix stages, sum
    localparam int ADD_LATENCY = 5;

    // per-bit carry behavior
    typedef enum logic [1:0] {
        CARRY_KILL = 2'b00,
        CARRY_PROP = 2'b10,
        CARRY_GEN  = 2'b11
    } carry_code_e;

    // carry out for each value of the carry in
    typedef struct packed {
        logic upper;
        logic lower;
    } carry_bits_t;

    // named code when produced, raw bits when combined
    typedef union packed {
        carry_code_e code;
        carry_bits_t bits;
    } carry_state_u;

endpackage

// File: design/pgk_encode.sv
`timescale 1ns/100ps

module pgk_encode
    import prefix_adder_pkg::*;
#(
    parameter int WIDTH = DATA_W
)
(
    input  logic                     clk,
    input  logic [WIDTH-1:0]         a,
    input  logic [WIDTH-1:0]         b,
    input  logic                     cin,
    output carry_state_u [WIDTH-1:0] pgk_q
);

    carry_state_u [WIDTH-1:0] pgk_d;
    logic                     maj0;

    // carry in folded into bit 0, so bit 0 is never propagate
    assign maj0 = (a[0] & b[0]) | (b[0] & cin) | (cin & a[0]);

    always_comb
    begin
        pgk_d[0].code = maj0 ? CARRY_GEN : CARRY_KILL;
        for (int i = 1; i < WIDTH; i++)
        begin
            if (a[i] & b[i])
                pgk_d[i].code = CARRY_GEN;
            else if (a[i] | b[i])
                pgk_d[i].code = CARRY_PROP;
            else
                pgk_d[i].code = CARRY_KILL;
        end
    end

    always_ff @(posedge clk)
    begin
        pgk_q <= pgk_d;
    end

endmodule

// File: design/prefix_stage.sv
`timescale 1ns/100ps

module prefix_stage
    import prefix_adder_pkg::*;
#(
    parameter int WIDTH      = DATA_W,
    parameter int FIRST_SPAN = 1,
    parameter int LEVELS     = 1
)
(
    input  logic                     clk,
    input  carry_state_u [WIDTH-1:0] state_d,
    output carry_state_u [WIDTH-1:0] state_q
);

    // lvl[0] is the stage input, lvl[LEVELS] the value to register
    carry_state_u [WIDTH-1:0] lvl [LEVELS+1];

    // hi covers the upper bits of the group, lo the bits just below it
    function automatic carry_state_u combine(carry_state_u hi, carry_state_u lo);
        carry_state_u res;
        res.bits.upper = hi.bits.lower | (hi.bits.upper & lo.bits.upper);
        res.bits.lower = hi.bits.lower | (hi.bits.upper & lo.bits.lower);
        return res;
    endfunction

    always_comb
    begin
        int span;
        lvl[0] = state_d;
        for (int l = 0; l < LEVELS; l++)
        begin
            span = FIRST_SPAN << l;
            for (int i = 0; i < WIDTH; i++)
            begin
                // bits below the span already hold their final prefix
                if (i >= span)
                    lvl[l+1][i] = combine(lvl[l][i], lvl[l][i-span]);
                else
                    lvl[l+1][i] = lvl[l][i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        state_q <= lvl[LEVELS];
    end

endmodule

// File: design/operand_delay.sv
`timescale 1ns/100ps

module operand_delay
    import prefix_adder_pkg::*;
#(
    parameter int WIDTH = DATA_W,
    parameter int DEPTH = 4
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    input  logic             in_valid,
    output logic [WIDTH-1:0] half_sum,
    output logic             cin_dly,
    output logic             valid_dly
);

    logic [WIDTH-1:0] hs_pipe    [DEPTH];
    logic             cin_pipe   [DEPTH];
    logic             valid_pipe [DEPTH];

    always_ff @(posedge clk)
    begin
        hs_pipe[0]  <= a ^ b;
        cin_pipe[0] <= cin;
        for (int i = 1; i < DEPTH; i++)
        begin
            hs_pipe[i]  <= hs_pipe[i-1];
            cin_pipe[i] <= cin_pipe[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
                valid_pipe[i] <= 1'b0;
        end
        else
        begin
            valid_pipe[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++)
                valid_pipe[i] <= valid_pipe[i-1];
        end
    end

    assign half_sum  = hs_pipe[DEPTH-1];
    assign cin_dly   = cin_pipe[DEPTH-1];
    assign valid_dly = valid_pipe[DEPTH-1];

endmodule

// File: design/sum_stage.sv
`timescale 1ns/100ps

module sum_stage
    import prefix_adder_pkg::*;
#(
    parameter int WIDTH = DATA_W
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  carry_state_u [WIDTH-1:0] carry_state,
    input  logic [WIDTH-1:0]         half_sum,
    input  logic                     cin,
    input  logic                     valid,
    output logic [WIDTH-1:0]         sum,
    output logic                     cout,
    output logic                     out_valid
);

    logic [WIDTH-1:0] carry_in;

    // every prefix covers bit 0, so the upper field is the real carry
    always_comb
    begin
        carry_in[0] = cin;
        for (int i = 1; i < WIDTH; i++)
            carry_in[i] = carry_state[i-1].bits.upper;
    end

    always_ff @(posedge clk)
    begin
        sum  <= half_sum ^ carry_in;
        cout <= carry_state[WIDTH-1].bits.upper;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= valid;
    end

endmodule

// File: design/prefix_adder.sv
`timescale 1ns/100ps

module prefix_adder
    import prefix_adder_pkg::*;
#(
    parameter int WIDTH = DATA_W
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    input  logic             in_valid,
    output logic [WIDTH-1:0] sum,
    output logic             cout,
    output logic             out_valid
);

    carry_state_u [WIDTH-1:0] pgk_q;
    carry_state_u [WIDTH-1:0] span2_q;
    carry_state_u [WIDTH-1:0] span8_q;
    carry_state_u [WIDTH-1:0] span16_q;

    logic [WIDTH-1:0] half_sum_dly;
    logic             cin_dly;
    logic             valid_dly;

    pgk_encode #(.WIDTH(WIDTH)) i_pgk_encode (
        .clk   (clk),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .pgk_q (pgk_q)
    );

    // spans 1 and 2
    prefix_stage #(.WIDTH(WIDTH), .FIRST_SPAN(1), .LEVELS(2)) i_prefix_stage_0 (
        .clk     (clk),
        .state_d (pgk_q),
        .state_q (span2_q)
    );

    // spans 4 and 8
    prefix_stage #(.WIDTH(WIDTH), .FIRST_SPAN(4), .LEVELS(2)) i_prefix_stage_1 (
        .clk     (clk),
        .state_d (span2_q),
        .state_q (span8_q)
    );

    prefix_stage #(.WIDTH(WIDTH), .FIRST_SPAN(16), .LEVELS(1)) i_prefix_stage_2 (
        .clk     (clk),
        .state_d (span8_q),
        .state_q (span16_q)
    );

    // matches encode plus the three prefix stages
    operand_delay #(.WIDTH(WIDTH), .DEPTH(ADD_LATENCY - 1)) i_operand_delay (
        .clk       (clk),
        .rst       (rst),
        .a         (a),
        .b         (b),
        .cin       (cin),
        .in_valid  (in_valid),
        .half_sum  (half_sum_dly),
        .cin_dly   (cin_dly),
        .valid_dly (valid_dly)
    );

    sum_stage #(.WIDTH(WIDTH)) i_sum_stage (
        .clk         (clk),
        .rst         (rst),
        .carry_state (span16_q),
        .half_sum    (half_sum_dly),
        .cin         (cin_dly),
        .valid       (valid_dly),
        .sum         (sum),
        .cout        (cout),
        .out_valid   (out_valid)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD = 10
)
(
    output logic clk
);

    initial
        clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: sim/prefix_adder_tb.sv
`timescale 1ns/100ps

module prefix_adder_tb
    import prefix_adder_pkg::*;
();

    localparam int WIDTH        = DATA_W;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int CIN_PAIRS    = 6;
    localparam int STREAM_LEN   = 200;
    localparam int BUBBLE_LEN   = 100;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_LIMIT  = ADD_LATENCY + 4;
    // upper bound on the cycles all tests together take
    localparam int TEST_CYCLES  = RESET_CYCLES + ADD_LATENCY + 16 + 2 * CIN_PAIRS + STREAM_LEN
                                  + BUBBLE_LEN * (MAX_GAP + 1) + 4 * (2 * DRAIN_LIMIT);
    localparam int MARGIN       = 50;

    logic             clk;
    logic             rst;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             cin;
    logic             in_valid;
    logic [WIDTH-1:0] sum;
    logic             cout;
    logic             out_valid;

    // expected {cout, sum}, the cycle each input was presented, and results seen
    logic [WIDTH:0] exp_q [$];
    int             stamp_q [$];
    logic [WIDTH:0] res_q [$];
    logic [WIDTH:0] expected;
    int             started;

    int     cyc = 0;
    int     n_results = 0;
    int     n_checks = 0;
    int     n_errors = 0;
    integer seed;

    tb_clock #(.PERIOD(CLK_PERIOD)) i_tb_clock (
        .clk (clk)
    );

    prefix_adder #(.WIDTH(WIDTH)) i_prefix_adder (
        .clk       (clk),
        .rst       (rst),
        .a         (a),
        .b         (b),
        .cin       (cin),
        .in_valid  (in_valid),
        .sum       (sum),
        .cout      (cout),
        .out_valid (out_valid)
    );

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic fail(input string what);
        n_errors++;
        $display("error in cycle %0d: %s", cyc, what);
    endtask

    task automatic send(input logic [WIDTH-1:0] x, input logic [WIDTH-1:0] y, input logic c);
        @(posedge clk);
        a        <= x;
        b        <= y;
        cin      <= c;
        in_valid <= 1'b1;
        exp_q.push_back({1'b0, x} + {1'b0, y} + {{WIDTH{1'b0}}, c});
        // presented during the cycle after this edge
        stamp_q.push_back(cyc + 1);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            in_valid <= 1'b0;
            // junk operands while idle
            a        <= WIDTH'($random(seed));
            b        <= WIDTH'($random(seed));
            cin      <= 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0)
        begin
            fail($sformatf("%0d results never came out", exp_q.size()));
            exp_q.delete();
            stamp_q.delete();
        end
        // room for stray results to show up
        repeat (2) @(negedge clk);
    endtask

    task automatic test_reset();
        // additions offered during reset must be dropped
        repeat (RESET_CYCLES - 1)
        begin
            @(posedge clk);
            a        <= WIDTH'($random(seed));
            b        <= WIDTH'($random(seed));
            cin      <= 1'($random(seed));
            in_valid <= 1'b1;
        end
        @(posedge clk);
        rst      <= 1'b0;
        in_valid <= 1'b0;
        repeat (ADD_LATENCY)
        begin
            @(negedge clk);
            check("out_valid", 64'(0), 64'(out_valid));
        end
    endtask

    task automatic test_corners();
        logic [WIDTH-1:0] ones;
        logic [WIDTH-1:0] alt;
        logic [WIDTH-1:0] msb;
        ones = '1;
        alt  = {(WIDTH / 2){2'b10}};
        msb  = {1'b1, {(WIDTH - 1){1'b0}}};
        send('0, '0, 1'b0);
        send('0, '0, 1'b1);
        send(ones, WIDTH'(1), 1'b0);
        send(ones, '0, 1'b1);
        send(ones, ones, 1'b1);
        send(ones, ones, 1'b0);
        // full-length propagate chains
        send(alt, ~alt, 1'b0);
        send(alt, ~alt, 1'b1);
        send(alt, alt, 1'b0);
        send(~alt, ~alt, 1'b1);
        send(msb, msb, 1'b0);
        drain();
    endtask

    task automatic test_carry_in();
        logic [WIDTH-1:0] x [CIN_PAIRS];
        logic [WIDTH-1:0] y [CIN_PAIRS];
        logic [WIDTH:0]   r0;
        logic [WIDTH:0]   r1;
        x[0] = '1;
        y[0] = '0;
        x[1] = '0;
        y[1] = '0;
        for (int i = 2; i < CIN_PAIRS; i++)
        begin
            x[i] = WIDTH'($random(seed));
            y[i] = WIDTH'($random(seed));
        end
        res_q.delete();
        for (int i = 0; i < CIN_PAIRS; i++)
        begin
            send(x[i], y[i], 1'b0);
            send(x[i], y[i], 1'b1);
        end
        drain();
        if (res_q.size() != 2 * CIN_PAIRS)
            fail("carry-in test did not get one result per addition");
        else
        begin
            for (int i = 0; i < CIN_PAIRS; i++)
            begin
                r0 = res_q.pop_front();
                r1 = res_q.pop_front();
                check("cin_delta", 64'(r0) + 64'd1, 64'(r1));
            end
        end
    endtask

    task automatic test_stream();
        for (int i = 0; i < STREAM_LEN; i++)
            send(WIDTH'($random(seed)), WIDTH'($random(seed)), 1'($random(seed)));
        drain();
    endtask

    task automatic test_bubbles();
        int start;
        int gap;
        start = n_results;
        for (int i = 0; i < BUBBLE_LEN; i++)
        begin
            send(WIDTH'($random(seed)), WIDTH'($random(seed)), 1'($random(seed)));
            gap = {$random(seed)} % (MAX_GAP + 1);
            idle(gap);
        end
        drain();
        check("result_count", 64'(BUBBLE_LEN), 64'(n_results - start));
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        cyc = cyc + 1;
        if (rst && out_valid !== 1'b0)
            fail("out_valid not low during reset");
        else if (out_valid === 1'b1)
        begin
            n_results++;
            res_q.push_back({cout, sum});
            if (exp_q.size() == 0)
                fail("result came out with no addition pending");
            else
            begin
                expected = exp_q.pop_front();
                started  = stamp_q.pop_front();
                check("sum", 64'(expected[WIDTH-1:0]), 64'(sum));
                check("cout", 64'(expected[WIDTH]), 64'(cout));
                check("latency", 64'(ADD_LATENCY), 64'(cyc - started));
            end
        end
        else if (out_valid !== 1'b0)
            fail("out_valid is unknown");
    end

    initial
    begin
        #((TEST_CYCLES + ADD_LATENCY + MARGIN) * CLK_PERIOD);
        $display("timeout: the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial
    begin
        seed     = 32'hff75_4b49;
        rst      = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        cin      = 1'b0;
        test_reset();
        test_corners();
        test_carry_in();
        test_stream();
        test_bubbles();
        $display("checks: %0d, results: %0d, errors: %0d", n_checks, n_results, n_errors);
        if (n_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: files.f
design/prefix_adder_pkg.sv
design/pgk_encode.sv
design/prefix_stage.sv
design/operand_delay.sv
design/sum_stage.sv
design/prefix_adder.sv
sim/tb_clock.sv
sim/prefix_adder_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the prefix adder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module prefix_adder_tb \
    -f files.f \
    --Mdir obj_dir \
    -o prefix_adder_sim

output=$(./obj_dir/prefix_adder_sim)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
